// File: hw/hyper_w_pkg.sv
package hyper_w_pkg;

  // Bus and PHY geometry
  localparam int unsigned AxiDataWidth = 32;
  localparam int unsigned AxiBytes     = AxiDataWidth / 8;
  localparam int unsigned PhyBytes     = 2;

  // Beat buffer depth, a power of two
  localparam int unsigned FifoDepth    = 4;
  localparam int unsigned LenWidth     = 8;

  // Burst command
  typedef struct packed {
    logic [$clog2(AxiBytes)-1:0] addr;
    logic [1:0]                  size;
    logic [LenWidth-1:0]         len;
  } aw_cmd_t;

  // Incoming data beat
  typedef struct packed {
    logic [AxiDataWidth-1:0] data;
    logic [AxiBytes-1:0]     strb;
  } w_beat_t;

  // Beat as stored in the buffer, with its own lane and size
  typedef struct packed {
    logic [AxiDataWidth-1:0]     data;
    logic [AxiBytes-1:0]         strb;
    logic [$clog2(AxiBytes)-1:0] lane;
    logic [1:0]                  size;
    logic                        first;
    logic                        last;
  } tagged_beat_t;

  // One word towards the PHY
  typedef struct packed {
    logic [8*PhyBytes-1:0] data;
    logic [PhyBytes-1:0]   strb;
    logic                  last;
  } phy_word_t;

endpackage

// File: hw/hyper_w_intake.sv
`timescale 1ns/1ns

module hyper_w_intake (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      aw_valid_i,
  input  hyper_w_pkg::aw_cmd_t      aw_i,
  output logic                      aw_ready_o,
  input  logic                      w_valid_i,
  input  hyper_w_pkg::w_beat_t      w_i,
  output logic                      w_ready_o,
  output logic                      push_o,
  output hyper_w_pkg::tagged_beat_t beat_o,
  input  logic                      full_i
);

  logic                                   open_q;
  logic                                   first_q;
  logic [1:0]                             size_q;
  logic [hyper_w_pkg::LenWidth-1:0]       remain_q;
  logic [$clog2(hyper_w_pkg::AxiBytes)-1:0] lane_q;
  logic [$clog2(hyper_w_pkg::AxiBytes)-1:0] lane_aligned;
  logic [$clog2(hyper_w_pkg::AxiBytes)-1:0] lane_next;
  logic [2:0]                             lane_step;
  logic                                   closing;
  logic                                   aw_fire;

  // Beats pass straight through when the buffer has room
  assign w_ready_o  = open_q && !full_i;
  assign push_o     = w_valid_i && w_ready_o;
  assign closing    = push_o && (remain_q == '0);
  assign aw_ready_o = !open_q || closing;
  assign aw_fire    = aw_valid_i && aw_ready_o;

  // Align down to the size boundary, then step one transfer forward
  assign lane_aligned = (lane_q >> size_q) << size_q;
  assign lane_step    = 3'd1 << size_q;
  assign lane_next    = lane_aligned + lane_step[1:0];

  always_comb begin
    beat_o.data  = w_i.data;
    beat_o.strb  = w_i.strb;
    beat_o.lane  = lane_q;
    beat_o.size  = size_q;
    beat_o.first = first_q;
    beat_o.last  = (remain_q == '0);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      open_q   <= 1'b0;
      first_q  <= 1'b0;
      size_q   <= '0;
      remain_q <= '0;
      lane_q   <= '0;
    end else begin
      if (push_o) begin
        remain_q <= remain_q - 1'b1;
        lane_q   <= lane_next;
        first_q  <= 1'b0;
        if (closing) begin
          open_q <= 1'b0;
        end
      end
      // A new command wins over the close in the same cycle
      if (aw_fire) begin
        open_q   <= 1'b1;
        first_q  <= 1'b1;
        size_q   <= aw_i.size;
        remain_q <= aw_i.len;
        lane_q   <= aw_i.addr;
      end
    end
  end

endmodule

// File: hw/hyper_w_fifo.sv
`timescale 1ns/1ns

module hyper_w_fifo (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      push_i,
  input  hyper_w_pkg::tagged_beat_t beat_i,
  output logic                      full_o,
  input  logic                      pop_i,
  output hyper_w_pkg::tagged_beat_t beat_o,
  output logic                      empty_o
);

  hyper_w_pkg::tagged_beat_t mem_q [hyper_w_pkg::FifoDepth];

  logic [$clog2(hyper_w_pkg::FifoDepth)-1:0] wr_ptr_q;
  logic [$clog2(hyper_w_pkg::FifoDepth)-1:0] rd_ptr_q;
  logic [$clog2(hyper_w_pkg::FifoDepth+1)-1:0] count_q;
  logic do_push;
  logic do_pop;

  assign full_o  = (count_q == hyper_w_pkg::FifoDepth);
  assign empty_o = (count_q == '0);
  assign beat_o  = mem_q[rd_ptr_q];

  // A pop frees the slot a full buffer needs for the push
  assign do_pop  = pop_i && !empty_o;
  assign do_push = push_i && (!full_o || do_pop);

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= beat_i;
    end
  end

  // Depth is a power of two so the pointers wrap on their own
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10: count_q <= count_q + 1'b1;
        2'b01: count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: hw/hyper_w2phy.sv
`timescale 1ns/1ns

module hyper_w2phy (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  hyper_w_pkg::tagged_beat_t beat_i,
  input  logic                      empty_i,
  output logic                      pop_o,
  output logic                      word_valid_o,
  output hyper_w_pkg::phy_word_t    word_o,
  input  logic                      word_ready_i
);

  // Output word register
  hyper_w_pkg::phy_word_t word_q;
  hyper_w_pkg::phy_word_t word_d;
  logic                   word_valid_q;
  logic                   load;
  logic                   out_free;

  // Upper half of a full beat comes next
  logic half_q;
  logic half_d;

  // Gather register for narrow beats
  logic [8*hyper_w_pkg::PhyBytes-1:0] gdata_q;
  logic [8*hyper_w_pkg::PhyBytes-1:0] gdata_d;
  logic [hyper_w_pkg::PhyBytes-1:0]   gstrb_q;
  logic [hyper_w_pkg::PhyBytes-1:0]   gstrb_d;

  logic                               is_full;
  logic                               skip_lower;
  logic [2:0]                         lane_end;
  logic [hyper_w_pkg::AxiBytes-1:0]   lane_mask;
  logic [hyper_w_pkg::AxiBytes-1:0]   strb_eff;
  logic [8*hyper_w_pkg::PhyBytes-1:0] merge_data;
  logic [hyper_w_pkg::PhyBytes-1:0]   merge_strb;
  logic                               emit;

  assign out_free     = !word_valid_q || word_ready_i;
  assign word_valid_o = word_valid_q;
  assign word_o       = word_q;

  assign is_full    = beat_i.size[1];
  assign skip_lower = beat_i.first && beat_i.lane[1];

  // Lanes from the beat's own lane up to the next size boundary
  always_comb begin
    lane_end = (({1'b0, beat_i.lane} >> beat_i.size) + 3'd1) << beat_i.size;
    for (int i = 0; i < hyper_w_pkg::AxiBytes; i++) begin
      lane_mask[i] = (i >= int'(beat_i.lane)) && (i < int'(lane_end));
    end
  end

  assign strb_eff = beat_i.strb & lane_mask;

  // Narrow merge into the half that holds the beat's lane
  always_comb begin
    int idx;
    merge_data = gdata_q;
    merge_strb = beat_i.first ? '0 : gstrb_q;
    for (int b = 0; b < hyper_w_pkg::PhyBytes; b++) begin
      idx = hyper_w_pkg::PhyBytes * int'(beat_i.lane[1]) + b;
      if (lane_mask[idx]) begin
        merge_data[8*b +: 8] = beat_i.data[8*idx +: 8];
        merge_strb[b]        = beat_i.strb[idx];
      end
    end
  end

  // Half complete once the next lane sits on a word boundary
  assign emit = beat_i.last || !lane_end[0];

  always_comb begin
    word_d  = word_q;
    half_d  = half_q;
    gdata_d = gdata_q;
    gstrb_d = gstrb_q;
    load    = 1'b0;
    pop_o   = 1'b0;
    if (!empty_i && out_free) begin
      if (is_full) begin
        load = 1'b1;
        if (half_q || skip_lower) begin
          word_d.data = beat_i.data[31:16];
          word_d.strb = strb_eff[3:2];
          word_d.last = beat_i.last;
          half_d      = 1'b0;
          pop_o       = 1'b1;
        end else begin
          // Beat stays at the head for its upper half
          word_d.data = beat_i.data[15:0];
          word_d.strb = strb_eff[1:0];
          word_d.last = 1'b0;
          half_d      = 1'b1;
        end
      end else begin
        pop_o = 1'b1;
        if (emit) begin
          load        = 1'b1;
          word_d.data = merge_data;
          word_d.strb = merge_strb;
          word_d.last = beat_i.last;
          gstrb_d     = '0;
        end else begin
          gdata_d = merge_data;
          gstrb_d = merge_strb;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_valid_q <= 1'b0;
      half_q       <= 1'b0;
      gstrb_q      <= '0;
    end else begin
      if (load) begin
        word_valid_q <= 1'b1;
      end else if (word_ready_i) begin
        word_valid_q <= 1'b0;
      end
      half_q  <= half_d;
      gstrb_q <= gstrb_d;
    end
  end

  always_ff @(posedge clk_i) begin
    word_q  <= word_d;
    gdata_q <= gdata_d;
  end

endmodule

// File: hw/hyper_phy_tx.sv
`timescale 1ns/1ns

module hyper_phy_tx (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   word_valid_i,
  input  hyper_w_pkg::phy_word_t word_i,
  output logic                   word_ready_o,
  output logic                   tx_valid_o,
  output logic [7:0]             tx_byte_o,
  output logic                   tx_mask_o,
  output logic                   tx_last_o,
  input  logic                   tx_ready_i
);

  hyper_w_pkg::phy_word_t word_q;
  logic                   busy_q;
  logic                   hi_q;
  logic                   take;
  logic                   byte_fire;

  assign byte_fire = busy_q && tx_ready_i;

  // Next word can enter while its predecessor's upper byte leaves
  assign word_ready_o = !busy_q || (hi_q && tx_ready_i);
  assign take         = word_valid_i && word_ready_o;

  assign tx_valid_o = busy_q;
  assign tx_byte_o  = hi_q ? word_q.data[15:8] : word_q.data[7:0];
  assign tx_mask_o  = hi_q ? !word_q.strb[1] : !word_q.strb[0];
  assign tx_last_o  = busy_q && hi_q && word_q.last;

  always_ff @(posedge clk_i) begin
    if (take) begin
      word_q <= word_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      hi_q   <= 1'b0;
    end else begin
      if (take) begin
        busy_q <= 1'b1;
        hi_q   <= 1'b0;
      end else if (byte_fire) begin
        if (hi_q) begin
          busy_q <= 1'b0;
          hi_q   <= 1'b0;
        end else begin
          hi_q <= 1'b1;
        end
      end
    end
  end

endmodule

// File: hw/hyper_w_top.sv
`timescale 1ns/1ns

module hyper_w_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 aw_valid_i,
  input  hyper_w_pkg::aw_cmd_t aw_i,
  output logic                 aw_ready_o,
  input  logic                 w_valid_i,
  input  hyper_w_pkg::w_beat_t w_i,
  output logic                 w_ready_o,
  output logic                 tx_valid_o,
  output logic [7:0]           tx_byte_o,
  output logic                 tx_mask_o,
  output logic                 tx_last_o,
  input  logic                 tx_ready_i
);

  hyper_w_pkg::tagged_beat_t in_beat;
  hyper_w_pkg::tagged_beat_t head_beat;
  hyper_w_pkg::phy_word_t    word;
  logic                      push;
  logic                      full;
  logic                      pop;
  logic                      empty;
  logic                      word_valid;
  logic                      word_ready;

  hyper_w_intake i_intake (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .aw_valid_i (aw_valid_i),
    .aw_i       (aw_i),
    .aw_ready_o (aw_ready_o),
    .w_valid_i  (w_valid_i),
    .w_i        (w_i),
    .w_ready_o  (w_ready_o),
    .push_o     (push),
    .beat_o     (in_beat),
    .full_i     (full)
  );

  hyper_w_fifo i_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (push),
    .beat_i  (in_beat),
    .full_o  (full),
    .pop_i   (pop),
    .beat_o  (head_beat),
    .empty_o (empty)
  );

  hyper_w2phy i_w2phy (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .beat_i       (head_beat),
    .empty_i      (empty),
    .pop_o        (pop),
    .word_valid_o (word_valid),
    .word_o       (word),
    .word_ready_i (word_ready)
  );

  hyper_phy_tx i_phy_tx (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .word_valid_i (word_valid),
    .word_i       (word),
    .word_ready_o (word_ready),
    .tx_valid_o   (tx_valid_o),
    .tx_byte_o    (tx_byte_o),
    .tx_mask_o    (tx_mask_o),
    .tx_last_o    (tx_last_o),
    .tx_ready_i   (tx_ready_i)
  );

endmodule

// File: verif/tb_hyper_w.sv
`timescale 1ns/1ns

module tb_hyper_w;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       aw_valid_i;
  hyper_w_pkg::aw_cmd_t       aw_i;
  logic                       aw_ready_o;
  logic                       w_valid_i;
  hyper_w_pkg::w_beat_t       w_i;
  logic                       w_ready_o;
  logic                       tx_valid_o;
  logic [7:0]                 tx_byte_o;
  logic                       tx_mask_o;
  logic                       tx_last_o;
  logic                       tx_ready_i;

  // Expected bytes as {last, mask, byte}
  logic [9:0]  exp_q [$];
  logic [31:0] bdata [64];
  logic [3:0]  bstrb [64];
  logic [31:0] data_state;
  logic [31:0] ready_state;
  logic        random_ready;
  logic        stall;
  int          max_wait;

  hyper_w_top uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  // Back-pressure source
  always @(negedge clk_i) begin
    if (stall) begin
      tx_ready_i = 1'b0;
    end else if (random_ready) begin
      ready_state = lcg(ready_state);
      tx_ready_i  = ready_state[16];
    end else begin
      tx_ready_i = 1'b1;
    end
  end

  // Every accepted byte is checked against the queue
  always begin
    logic [9:0] exp;
    @(negedge clk_i);
    #2;
    if (rst_ni && tx_valid_o && tx_ready_i) begin
      if (exp_q.size() == 0) begin
        fail_now($sformatf("At %0t a byte came out that no test expected", $time));
      end
      exp = exp_q.pop_front();
      assert (tx_mask_o == exp[8]) else
        fail_now($sformatf("FAILED at %0t: tx_mask_o got %b expected %b",
                           $time, tx_mask_o, exp[8]));
      assert (tx_last_o == exp[9]) else
        fail_now($sformatf("FAILED at %0t: tx_last_o got %b expected %b",
                           $time, tx_last_o, exp[9]));
      // Masked bytes carry no defined data
      assert (exp[8] || tx_byte_o == exp[7:0]) else
        fail_now($sformatf("FAILED at %0t: tx_byte_o got %h expected %h",
                           $time, tx_byte_o, exp[7:0]));
    end
  end

  task automatic push_word(input logic [15:0] data, input logic [1:0] strb,
                           input logic last);
    exp_q.push_back({1'b0, !strb[0], data[7:0]});
    exp_q.push_back({last, !strb[1], data[15:8]});
  endtask

  // Reference model from the lane and word rules
  task automatic expect_burst(input int addr, input int size, input int len);
    int         lane;
    int         lend;
    logic [3:0] eff;
    logic [7:0] gbyte [2];
    logic [1:0] gstrb;
    lane  = addr;
    gstrb = 2'b00;
    for (int i = 0; i <= len; i++) begin
      if (i > 0) begin
        lane = (((lane >> size) << size) + (1 << size)) % 4;
      end
      lend = ((lane >> size) + 1) << size;
      if (size == 2) begin
        eff = 4'b0000;
        for (int l = lane; l < 4; l++) begin
          eff[l] = bstrb[i][l];
        end
        if (!(i == 0 && lane >= 2)) begin
          push_word(bdata[i][15:0], eff[1:0], 1'b0);
        end
        push_word(bdata[i][31:16], eff[3:2], i == len);
      end else begin
        for (int l = lane; l < lend; l++) begin
          gbyte[l % 2] = bdata[i][8*l +: 8];
          gstrb[l % 2] = bstrb[i][l];
        end
        if (i == len || lend % 2 == 0) begin
          push_word({gbyte[1], gbyte[0]}, gstrb, i == len);
          gstrb = 2'b00;
        end
      end
    end
  endtask

  task automatic fill_beats(input int n);
    for (int i = 0; i < n; i++) begin
      data_state = lcg(data_state);
      bdata[i]   = data_state;
      bstrb[i]   = 4'hf;
    end
  endtask

  // Valid stays high after the transfer until the caller's next negedge
  task automatic drive_cmd(input int addr, input int size, input int len);
    int   cycles;
    logic done;
    @(negedge clk_i);
    aw_i.addr  = addr[1:0];
    aw_i.size  = size[1:0];
    aw_i.len   = len[7:0];
    aw_valid_i = 1'b1;
    cycles     = 0;
    done       = 1'b0;
    while (!done) begin
      #1;
      done = aw_ready_o;
      @(posedge clk_i);
      cycles++;
      if (!done) begin
        if (cycles > max_wait) begin
          fail_now("Timeout waiting for aw_ready_o");
        end
        @(negedge clk_i);
      end
    end
  endtask

  task automatic drive_beat(input int i);
    int   cycles;
    logic done;
    @(negedge clk_i);
    w_i.data  = bdata[i];
    w_i.strb  = bstrb[i];
    w_valid_i = 1'b1;
    cycles    = 0;
    done      = 1'b0;
    while (!done) begin
      #1;
      done = w_ready_o;
      @(posedge clk_i);
      cycles++;
      if (!done) begin
        if (cycles > max_wait) begin
          fail_now("Timeout waiting for w_ready_o");
        end
        @(negedge clk_i);
      end
    end
  endtask

  task automatic send_burst(input int addr, input int size, input int len);
    expect_burst(addr, size, len);
    fork
      begin
        drive_cmd(addr, size, len);
        @(negedge clk_i);
        aw_valid_i = 1'b0;
      end
      begin
        for (int i = 0; i <= len; i++) begin
          drive_beat(i);
        end
        @(negedge clk_i);
        w_valid_i = 1'b0;
      end
    join
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk_i);
      #3;
      cycles++;
      if (cycles > max_wait) begin
        fail_now("Timeout waiting for the expected bytes to come out");
      end
    end while (exp_q.size() != 0 || tx_valid_o);
  endtask

  task automatic test_aligned_full();
    fill_beats(4);
    send_burst(0, 2, 3);
    wait_drain();
  endtask

  task automatic test_unaligned_full();
    fill_beats(2);
    send_burst(1, 2, 1);
    fill_beats(2);
    send_burst(2, 2, 1);
    wait_drain();
  endtask

  task automatic test_byte_burst();
    fill_beats(6);
    bstrb[2] = 4'h0;
    bstrb[4] = 4'hd;
    send_burst(1, 0, 5);
    wait_drain();
  endtask

  task automatic test_half_burst();
    fill_beats(4);
    send_burst(2, 1, 3);
    wait_drain();
  endtask

  task automatic test_back_pressure();
    random_ready = 1'b1;
    fill_beats(16);
    send_burst(0, 2, 15);
    wait_drain();
    random_ready = 1'b0;
    stall = 1'b1;
    fill_beats(8);
    fork
      send_burst(0, 2, 7);
      begin
        repeat (40) @(negedge clk_i);
        #1;
        assert (w_ready_o == 1'b0) else
          fail_now($sformatf("FAILED at %0t: w_ready_o got %b expected %b",
                             $time, w_ready_o, 1'b0));
        assert (aw_ready_o == 1'b0) else
          fail_now($sformatf("FAILED at %0t: aw_ready_o got %b expected %b",
                             $time, aw_ready_o, 1'b0));
        stall = 1'b0;
      end
    join
    wait_drain();
    assert (aw_ready_o == 1'b1) else
      fail_now($sformatf("FAILED at %0t: aw_ready_o got %b expected %b",
                         $time, aw_ready_o, 1'b1));
  endtask

  task automatic test_back_to_back();
    // Beats 0..2 form the size 0 burst and are kept in 5..7, 3..4 the size 2 burst
    fill_beats(5);
    for (int i = 0; i < 3; i++) begin
      bdata[i + 5] = bdata[i];
      bstrb[i + 5] = bstrb[i];
    end
    expect_burst(3, 0, 2);
    for (int i = 0; i < 2; i++) begin
      bdata[i] = bdata[i + 3];
      bstrb[i] = bstrb[i + 3];
    end
    expect_burst(0, 2, 1);
    fork
      begin
        drive_cmd(3, 0, 2);
        drive_cmd(0, 2, 1);
        @(negedge clk_i);
        aw_valid_i = 1'b0;
      end
      begin
        for (int i = 0; i < 3; i++) begin
          drive_beat(i + 5);
        end
        for (int i = 0; i < 2; i++) begin
          drive_beat(i);
        end
        @(negedge clk_i);
        w_valid_i = 1'b0;
      end
    join
    wait_drain();
  endtask

  initial begin
    rst_ni       = 1'b0;
    aw_valid_i   = 1'b0;
    aw_i         = '0;
    w_valid_i    = 1'b0;
    w_i          = '0;
    tx_ready_i   = 1'b1;
    random_ready = 1'b0;
    stall        = 1'b0;
    max_wait     = 1000;
    data_state   = 32'd31;
    ready_state  = 32'd31;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    assert (aw_ready_o && !w_ready_o && !tx_valid_o) else
      fail_now("Outputs after reset are not idle");
    test_aligned_full();
    test_unaligned_full();
    test_byte_burst();
    test_half_burst();
    test_back_pressure();
    test_back_to_back();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: tb.f
hw/hyper_w_pkg.sv
hw/hyper_w_intake.sv
hw/hyper_w_fifo.sv
hw/hyper_w2phy.sv
hw/hyper_phy_tx.sv
hw/hyper_w_top.sv
verif/tb_hyper_w.sv

// File: Makefile
OBJ_DIR := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module tb_hyper_w -Mdir $(OBJ_DIR) -o vtb_hyper_w

run: compile
	./$(OBJ_DIR)/vtb_hyper_w

clean:
	rm -rf $(OBJ_DIR)
